// File: dvbs2_pkg.sv
package dvbs2_pkg;

	// register bus
	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	localparam logic [ADDR_W-1:0] ADDR_MOD_MODE   = 4'd0;  // 0 qpsk, 1 bpsk
	localparam logic [ADDR_W-1:0] ADDR_SRRC_MODE  = 4'd1;  // 0 0.35, 1 0.25, 2/3 0.20
	localparam logic [ADDR_W-1:0] ADDR_FREQ_INV   = 4'd2;  // swap I and Q
	localparam logic [ADDR_W-1:0] ADDR_DROP_CNT   = 4'd11; // read only
	localparam logic [ADDR_W-1:0] ADDR_SAMPLE_CNT = 4'd12; // read only

	localparam logic [15:0] UNMAPPED_TAG = 16'hE000;

	localparam logic       MOD_MODE_RST  = 1'b0;
	localparam logic [1:0] SRRC_MODE_RST = 2'd2;
	localparam logic       FREQ_INV_RST  = 1'b0;

	// datapath widths
	localparam int SAMPLE_W  = 16;
	localparam int COEF_W    = 16;                      // Q1.14
	localparam int COEF_FRAC = 14;
	localparam int NTAPS     = 9;
	localparam int PROD_W    = SAMPLE_W + COEF_W;
	localparam int ACC_W     = PROD_W + $clog2(NTAPS);  // headroom for the tap sum
	localparam int ROUND_HALF = 2 ** (COEF_FRAC - 1);

	// symbol mapping
	localparam logic signed [SAMPLE_W-1:0] SYM_AMP = 16'sd11585; // 0.707
	localparam int QPSK_SYMS = 4;
	localparam int BPSK_SYMS = 8;

	localparam int SLOT_W = $clog2(2 * BPSK_SYMS);
	localparam logic [SLOT_W-1:0] SLOT_LAST_QPSK = SLOT_W'(2 * QPSK_SYMS - 1);
	localparam logic [SLOT_W-1:0] SLOT_LAST_BPSK = SLOT_W'(2 * BPSK_SYMS - 1);

	// root-raised-cosine taps at two samples per symbol, one row per roll-off
	localparam int SRRC_ROWS = 3;
	localparam logic signed [COEF_W-1:0] SRRC_COEF [SRRC_ROWS][NTAPS] = '{
		'{-16'sd410, 16'sd310, 16'sd2710, 16'sd7090, 16'sd9310,
			16'sd7090, 16'sd2710, 16'sd310, -16'sd410},   // 0.35
		'{-16'sd590, 16'sd150, 16'sd2890, 16'sd7310, 16'sd9520,
			16'sd7310, 16'sd2890, 16'sd150, -16'sd590},   // 0.25
		'{-16'sd690, 16'sd80, 16'sd2990, 16'sd7420, 16'sd9640,
			16'sd7420, 16'sd2990, 16'sd80, -16'sd690}     // 0.20
	};

endpackage

// File: dvbs2_cfg_regs.sv
`timescale 1ns/100ps

module dvbs2_cfg_regs (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        wen,
	input  logic [dvbs2_pkg::STRB_W-1:0] wstrb,
	input  logic [dvbs2_pkg::ADDR_W-1:0] waddr,
	input  logic [dvbs2_pkg::DATA_W-1:0] wdata,
	input  logic                        ren,
	input  logic [dvbs2_pkg::ADDR_W-1:0] raddr,
	input  logic                        drop_pulse,
	input  logic                        sample_oe,
	output logic [dvbs2_pkg::DATA_W-1:0] rdata,
	output logic                        mod_mode,
	output logic [1:0]                  srrc_mode,
	output logic                        freq_inv
);
	import dvbs2_pkg::*;

	logic              wr_pend;   // captured write waiting to be applied
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;   // strobed bytes merged over the old value
	logic [DATA_W-1:0] wr_old;    // current value of the write target
	logic [DATA_W-1:0] drop_cnt;
	logic [DATA_W-1:0] sample_cnt;

	// zero-extended register view, shared by readback and byte merge
	function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] word;
		case (addr)
			ADDR_MOD_MODE:   word = DATA_W'(mod_mode);
			ADDR_SRRC_MODE:  word = DATA_W'(srrc_mode);
			ADDR_FREQ_INV:   word = DATA_W'(freq_inv);
			ADDR_DROP_CNT:   word = drop_cnt;
			ADDR_SAMPLE_CNT: word = sample_cnt;
			default:         word = {UNMAPPED_TAG, {(DATA_W - 16 - ADDR_W){1'b0}}, addr};
		endcase
		return word;
	endfunction

	always_comb begin
		wr_old = read_word(waddr);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= wen;
		end
	end

	always_ff @(posedge clk) begin
		if (wen) begin
			wr_addr <= waddr;
			for (int b = 0; b < STRB_W; b++) begin
				wr_data[8*b +: 8] <= wstrb[b] ? wdata[8*b +: 8] : wr_old[8*b +: 8];
			end
		end
	end

	// second edge of the write path
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mod_mode  <= MOD_MODE_RST;
			srrc_mode <= SRRC_MODE_RST;
			freq_inv  <= FREQ_INV_RST;
		end else if (wr_pend) begin
			case (wr_addr)
				ADDR_MOD_MODE:  mod_mode  <= wr_data[0];
				ADDR_SRRC_MODE: srrc_mode <= wr_data[1:0];
				ADDR_FREQ_INV:  freq_inv  <= wr_data[0];
				default: ;                  // counters and holes ignore writes
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (ren) begin
			rdata <= read_word(raddr);      // held until the next read
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			drop_cnt   <= '0;
			sample_cnt <= '0;
		end else begin
			if (drop_pulse) begin
				drop_cnt <= drop_cnt + 1'b1;
			end
			if (sample_oe) begin
				sample_cnt <= sample_cnt + 1'b1;
			end
		end
	end

	a_wen_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		wen |-> !$isunknown(waddr))
		else $error("register write with unknown address");

endmodule

// File: symbol_mapper.sv
`timescale 1ns/100ps

module symbol_mapper (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                ts_valid,
	input  logic [7:0]                          ts_data,
	input  logic                                mod_mode,
	output logic                                drop_pulse,
	output logic                                x_valid,
	output logic signed [dvbs2_pkg::SAMPLE_W-1:0] x_re,
	output logic signed [dvbs2_pkg::SAMPLE_W-1:0] x_im
);
	import dvbs2_pkg::*;

	logic              busy;
	logic              mode_q;      // mode latched with the byte
	logic [7:0]        byte_q;      // msb is the next bit to map
	logic [SLOT_W-1:0] slot_q;      // even slots symbol, odd slots zero
	logic              last_slot;
	logic              accept;
	logic signed [SAMPLE_W-1:0] sym_re;
	logic signed [SAMPLE_W-1:0] sym_im;

	assign last_slot  = busy && (slot_q == (mode_q ? SLOT_LAST_BPSK : SLOT_LAST_QPSK));
	assign accept     = ts_valid && (!busy || last_slot);
	assign drop_pulse = ts_valid && !accept;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			slot_q <= '0;
		end else if (accept) begin
			busy   <= 1'b1;
			slot_q <= '0;
		end else if (last_slot) begin
			busy   <= 1'b0;
			slot_q <= '0;
		end else if (busy) begin
			slot_q <= slot_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			byte_q <= ts_data;
			mode_q <= mod_mode;
		end else if (busy && slot_q[0]) begin
			// consume the bits of the symbol just sent
			byte_q <= mode_q ? {byte_q[6:0], 1'b0} : {byte_q[5:0], 2'b00};
		end
	end

	// a 1 bit maps to the negative amplitude
	assign sym_re = byte_q[7] ? -SYM_AMP : SYM_AMP;
	assign sym_im = mode_q ? '0 : (byte_q[6] ? -SYM_AMP : SYM_AMP);

	assign x_valid = busy;
	assign x_re    = (busy && !slot_q[0]) ? sym_re : '0;
	assign x_im    = (busy && !slot_q[0]) ? sym_im : '0;

	// slot counter stays inside the burst of the latched mode
	a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
		x_valid |-> (slot_q <= (mode_q ? SLOT_LAST_BPSK : SLOT_LAST_QPSK)))
		else $error("x_valid ran past the slot count");

endmodule

// File: srrc_tap.sv
`timescale 1ns/100ps

module srrc_tap #(
	parameter int TAP_IDX = 0
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                x_valid,
	input  logic [1:0]                          srrc_mode,
	input  logic signed [dvbs2_pkg::SAMPLE_W-1:0] d_in_re,
	input  logic signed [dvbs2_pkg::SAMPLE_W-1:0] d_in_im,
	output logic signed [dvbs2_pkg::SAMPLE_W-1:0] d_out_re,
	output logic signed [dvbs2_pkg::SAMPLE_W-1:0] d_out_im,
	output logic signed [dvbs2_pkg::PROD_W-1:0]   prod_re,
	output logic signed [dvbs2_pkg::PROD_W-1:0]   prod_im
);
	import dvbs2_pkg::*;

	logic signed [COEF_W-1:0] coef;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d_out_re <= '0;
			d_out_im <= '0;
		end else if (x_valid) begin
			d_out_re <= d_in_re;    // shift one place down the line
			d_out_im <= d_in_im;
		end
	end

	// modes 2 and 3 share the 0.20 row
	assign coef = SRRC_COEF[(srrc_mode == 2'd3) ? 2 : srrc_mode][TAP_IDX];

	assign prod_re = d_out_re * coef;
	assign prod_im = d_out_im * coef;

endmodule

// File: srrc_output_stage.sv
`timescale 1ns/100ps

module srrc_output_stage (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                x_valid,
	input  logic                                freq_inv,
	input  logic signed [dvbs2_pkg::PROD_W-1:0]   prod_re [dvbs2_pkg::NTAPS],
	input  logic signed [dvbs2_pkg::PROD_W-1:0]   prod_im [dvbs2_pkg::NTAPS],
	output logic                                sample_oe,
	output logic signed [dvbs2_pkg::SAMPLE_W-1:0] sample_re,
	output logic signed [dvbs2_pkg::SAMPLE_W-1:0] sample_im
);
	import dvbs2_pkg::*;

	logic x_valid_d;    // cells hold the new sample on this cycle
	logic signed [ACC_W-1:0] sum_re;
	logic signed [ACC_W-1:0] sum_im;

	// round half up, drop the fraction, clamp to the sample range
	function automatic logic signed [SAMPLE_W-1:0] round_sat(input logic signed [ACC_W-1:0] acc);
		logic signed [ACC_W-1:0] shifted;
		logic signed [SAMPLE_W-1:0] result;
		shifted = (acc + ROUND_HALF) >>> COEF_FRAC;
		if (&shifted[ACC_W-1:SAMPLE_W-1] || ~|shifted[ACC_W-1:SAMPLE_W-1]) begin
			result = shifted[SAMPLE_W-1:0];
		end else if (shifted[ACC_W-1]) begin
			result = {1'b1, {(SAMPLE_W - 1){1'b0}}};
		end else begin
			result = {1'b0, {(SAMPLE_W - 1){1'b1}}};
		end
		return result;
	endfunction

	always_comb begin
		sum_re = '0;
		sum_im = '0;
		for (int k = 0; k < NTAPS; k++) begin
			sum_re = sum_re + prod_re[k];
			sum_im = sum_im + prod_im[k];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x_valid_d <= 1'b0;
			sample_oe <= 1'b0;
		end else begin
			x_valid_d <= x_valid;
			sample_oe <= x_valid_d;
		end
	end

	always_ff @(posedge clk) begin
		if (x_valid_d) begin
			if (freq_inv) begin
				sample_re <= round_sat(sum_im);  // spectrum inversion
				sample_im <= round_sat(sum_re);
			end else begin
				sample_re <= round_sat(sum_re);
				sample_im <= round_sat(sum_im);
			end
		end
	end

	// a valid output needs a mapper strobe two cycles back and a defined sample
	a_oe_follows_x: assert property (@(posedge clk) disable iff (!rst_n)
		sample_oe |-> ($past(x_valid, 2) && !$isunknown({sample_re, sample_im})))
		else $error("sample_oe without x_valid two cycles before or with unknown sample");

endmodule

// File: dvbs2_mod_top.sv
`timescale 1ns/100ps

module dvbs2_mod_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                wen,
	input  logic [dvbs2_pkg::STRB_W-1:0]        wstrb,
	input  logic [dvbs2_pkg::ADDR_W-1:0]        waddr,
	input  logic [dvbs2_pkg::DATA_W-1:0]        wdata,
	input  logic                                ren,
	input  logic [dvbs2_pkg::ADDR_W-1:0]        raddr,
	input  logic                                ts_valid,
	input  logic [7:0]                          ts_data,
	output logic [dvbs2_pkg::DATA_W-1:0]        rdata,
	output logic                                sample_oe,
	output logic signed [dvbs2_pkg::SAMPLE_W-1:0] sample_re,
	output logic signed [dvbs2_pkg::SAMPLE_W-1:0] sample_im
);
	import dvbs2_pkg::*;

	logic       mod_mode;
	logic [1:0] srrc_mode;
	logic       freq_inv;
	logic       drop_pulse;
	logic       x_valid;

	// delay line, element 0 is the mapper output
	logic signed [SAMPLE_W-1:0] chain_re [NTAPS+1];
	logic signed [SAMPLE_W-1:0] chain_im [NTAPS+1];
	logic signed [PROD_W-1:0]   prod_re  [NTAPS];
	logic signed [PROD_W-1:0]   prod_im  [NTAPS];

	dvbs2_cfg_regs u_cfg_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.wen        (wen),
		.wstrb      (wstrb),
		.waddr      (waddr),
		.wdata      (wdata),
		.ren        (ren),
		.raddr      (raddr),
		.drop_pulse (drop_pulse),
		.sample_oe  (sample_oe),
		.rdata      (rdata),
		.mod_mode   (mod_mode),
		.srrc_mode  (srrc_mode),
		.freq_inv   (freq_inv)
	);

	symbol_mapper u_mapper (
		.clk        (clk),
		.rst_n      (rst_n),
		.ts_valid   (ts_valid),
		.ts_data    (ts_data),
		.mod_mode   (mod_mode),
		.drop_pulse (drop_pulse),
		.x_valid    (x_valid),
		.x_re       (chain_re[0]),
		.x_im       (chain_im[0])
	);

	for (genvar g = 0; g < NTAPS; g++) begin : g_tap
		srrc_tap #(
			.TAP_IDX (g)
		) u_tap (
			.clk       (clk),
			.rst_n     (rst_n),
			.x_valid   (x_valid),
			.srrc_mode (srrc_mode),
			.d_in_re   (chain_re[g]),
			.d_in_im   (chain_im[g]),
			.d_out_re  (chain_re[g+1]),
			.d_out_im  (chain_im[g+1]),
			.prod_re   (prod_re[g]),
			.prod_im   (prod_im[g])
		);
	end

	srrc_output_stage u_out_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.x_valid   (x_valid),
		.freq_inv  (freq_inv),
		.prod_re   (prod_re),
		.prod_im   (prod_im),
		.sample_oe (sample_oe),
		.sample_re (sample_re),
		.sample_im (sample_im)
	);

endmodule

// File: tb_dvbs2_mod.sv
`timescale 1ns/100ps

module tb_dvbs2_mod;
	import dvbs2_pkg::*;

	localparam logic [1:0] K_WR   = 2'd0;  // register write
	localparam logic [1:0] K_RD   = 2'd1;  // read and expect data
	localparam logic [1:0] K_BYTE = 2'd2;  // one stream byte
	localparam logic [1:0] K_BUSY = 2'd3;  // byte, then a second one while busy

	typedef struct packed {
		logic [1:0]  kind;
		logic        rnd;    // byte comes from $urandom
		logic [3:0]  strb;
		logic [3:0]  addr;
		logic [31:0] data;   // write data, expected read data or byte
	} entry_t;

	localparam int N_ENTRIES = 35;
	localparam entry_t STIM [N_ENTRIES] = '{
		'{K_RD,   1'b0, 4'h0, ADDR_MOD_MODE,   32'h0},
		'{K_RD,   1'b0, 4'h0, ADDR_SRRC_MODE,  32'h2},
		'{K_RD,   1'b0, 4'h0, ADDR_FREQ_INV,   32'h0},
		'{K_RD,   1'b0, 4'h0, ADDR_DROP_CNT,   32'h0},
		'{K_RD,   1'b0, 4'h0, ADDR_SAMPLE_CNT, 32'h0},
		'{K_RD,   1'b0, 4'h0, 4'd5,            32'he000_0005},
		'{K_WR,   1'b0, 4'h2, ADDR_SRRC_MODE,  32'h0000_0300},
		'{K_RD,   1'b0, 4'h0, ADDR_SRRC_MODE,  32'h2},
		'{K_WR,   1'b0, 4'h1, ADDR_SRRC_MODE,  32'hffff_ff00},
		'{K_RD,   1'b0, 4'h0, ADDR_SRRC_MODE,  32'h0},
		'{K_WR,   1'b0, 4'h0, ADDR_MOD_MODE,   32'h1},
		'{K_RD,   1'b0, 4'h0, ADDR_MOD_MODE,   32'h0},
		'{K_WR,   1'b0, 4'hf, ADDR_FREQ_INV,   32'hffff_ffff},
		'{K_RD,   1'b0, 4'h0, ADDR_FREQ_INV,   32'h1},
		'{K_WR,   1'b0, 4'hf, ADDR_DROP_CNT,   32'hffff_ffff},
		'{K_RD,   1'b0, 4'h0, ADDR_DROP_CNT,   32'h0},
		'{K_WR,   1'b0, 4'h1, ADDR_FREQ_INV,   32'h0},
		'{K_BYTE, 1'b0, 4'h0, 4'd0,            32'h1b},   // qpsk, roll-off 0.35
		'{K_BYTE, 1'b1, 4'h0, 4'd0,            32'h0},
		'{K_WR,   1'b0, 4'h1, ADDR_SRRC_MODE,  32'h1},
		'{K_BYTE, 1'b0, 4'h0, 4'd0,            32'he4},
		'{K_WR,   1'b0, 4'hf, ADDR_SRRC_MODE,  32'h2},
		'{K_BYTE, 1'b1, 4'h0, 4'd0,            32'h0},
		'{K_WR,   1'b0, 4'h1, ADDR_SRRC_MODE,  32'h3},
		'{K_BYTE, 1'b0, 4'h0, 4'd0,            32'h5a},
		'{K_WR,   1'b0, 4'h1, ADDR_MOD_MODE,   32'h1},    // bpsk from here
		'{K_BYTE, 1'b0, 4'h0, 4'd0,            32'ha5},
		'{K_BYTE, 1'b1, 4'h0, 4'd0,            32'h0},
		'{K_WR,   1'b0, 4'h1, ADDR_FREQ_INV,   32'h1},
		'{K_BYTE, 1'b0, 4'h0, 4'd0,            32'h3c},
		'{K_WR,   1'b0, 4'h1, ADDR_MOD_MODE,   32'h0},
		'{K_BYTE, 1'b1, 4'h0, 4'd0,            32'h0},    // qpsk, inverted
		'{K_BUSY, 1'b0, 4'h0, 4'd0,            32'h96},
		'{K_RD,   1'b0, 4'h0, ADDR_DROP_CNT,   32'h1},
		'{K_RD,   1'b0, 4'h0, ADDR_SAMPLE_CNT, 32'h0}     // compared with model count
	};

	logic clk = 1'b0;
	logic rst_n;
	logic wen;
	logic [STRB_W-1:0] wstrb;
	logic [ADDR_W-1:0] waddr;
	logic [DATA_W-1:0] wdata;
	logic ren;
	logic [ADDR_W-1:0] raddr;
	logic ts_valid;
	logic [7:0] ts_data;
	logic [DATA_W-1:0] rdata;
	logic sample_oe;
	logic signed [SAMPLE_W-1:0] sample_re;
	logic signed [SAMPLE_W-1:0] sample_im;

	// shadow of the settings, reset values
	logic       sh_mod  = 1'b0;
	logic [1:0] sh_srrc = 2'd2;
	logic       sh_inv  = 1'b0;

	logic signed [SAMPLE_W-1:0] hist_re [NTAPS] = '{default: '0};  // index 0 newest
	logic signed [SAMPLE_W-1:0] hist_im [NTAPS] = '{default: '0};
	logic signed [SAMPLE_W-1:0] exp_re [$];
	logic signed [SAMPLE_W-1:0] exp_im [$];
	logic signed [SAMPLE_W-1:0] obs_re [$];
	logic signed [SAMPLE_W-1:0] obs_im [$];
	int checked = 0;
	int errors = 0;

	dvbs2_mod_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.wen       (wen),
		.wstrb     (wstrb),
		.waddr     (waddr),
		.wdata     (wdata),
		.ren       (ren),
		.raddr     (raddr),
		.ts_valid  (ts_valid),
		.ts_data   (ts_data),
		.rdata     (rdata),
		.sample_oe (sample_oe),
		.sample_re (sample_re),
		.sample_im (sample_im)
	);

	always #50 clk = ~clk;

	always @(negedge clk) begin
		if (sample_oe) begin
			obs_re.push_back(sample_re);
			obs_im.push_back(sample_im);
		end
	end

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] expv);
		if (got !== expv) begin
			errors++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, expv);
			$display("Test failures found");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0d ns while waiting for %s", $time, what);
		$display("Test failures found");
		$fatal(1, "wait loop timed out");
	endtask

	// round half up, drop 14 fraction bits, clamp to 16 bits
	function automatic logic signed [SAMPLE_W-1:0] round_clip(input longint acc);
		longint v;
		v = (acc + 64'sd8192) >>> 14;
		if (v > 64'sd32767) begin
			v = 64'sd32767;
		end else if (v < -64'sd32768) begin
			v = -64'sd32768;
		end
		return 16'(v);
	endfunction

	function automatic void filter_step(input logic signed [SAMPLE_W-1:0] re,
			input logic signed [SAMPLE_W-1:0] im);
		longint acc_re;
		longint acc_im;
		int row;
		for (int k = NTAPS - 1; k > 0; k--) begin
			hist_re[k] = hist_re[k-1];
			hist_im[k] = hist_im[k-1];
		end
		hist_re[0] = re;
		hist_im[0] = im;
		row = (sh_srrc == 2'd3) ? 2 : int'(sh_srrc);  // modes 2 and 3 are roll-off 0.20
		acc_re = 0;
		acc_im = 0;
		for (int k = 0; k < NTAPS; k++) begin
			acc_re += longint'(hist_re[k]) * longint'(SRRC_COEF[row][k]);
			acc_im += longint'(hist_im[k]) * longint'(SRRC_COEF[row][k]);
		end
		exp_re.push_back(sh_inv ? round_clip(acc_im) : round_clip(acc_re));
		exp_im.push_back(sh_inv ? round_clip(acc_re) : round_clip(acc_im));
	endfunction

	function automatic void model_byte(input logic [7:0] b);
		logic signed [SAMPLE_W-1:0] re;
		logic signed [SAMPLE_W-1:0] im;
		int bit_pos;
		bit_pos = 7;  // msb first
		for (int s = 0; s < (sh_mod ? BPSK_SYMS : QPSK_SYMS); s++) begin
			re = b[bit_pos] ? -SYM_AMP : SYM_AMP;
			if (sh_mod) begin
				im = '0;
				bit_pos -= 1;
			end else begin
				im = b[bit_pos-1] ? -SYM_AMP : SYM_AMP;
				bit_pos -= 2;
			end
			filter_step(re, im);
			filter_step('0, '0);  // zero stuffing
		end
	endfunction

	task automatic write_reg(input logic [3:0] strb, input logic [3:0] addr,
			input logic [31:0] data);
		wen = 1'b1;
		wstrb = strb;
		waddr = addr;
		wdata = data;
		@(posedge clk);
		#10;
		wen = 1'b0;
		if (strb[0]) begin
			case (addr)
				ADDR_MOD_MODE:  sh_mod = data[0];
				ADDR_SRRC_MODE: sh_srrc = data[1:0];
				ADDR_FREQ_INV:  sh_inv = data[0];
				default: ;
			endcase
		end
		@(posedge clk);  // write lands in the register here
		#10;
	endtask

	task automatic read_reg(input logic [3:0] addr, input logic [31:0] expv);
		ren = 1'b1;
		raddr = addr;
		@(posedge clk);
		#10;
		ren = 1'b0;
		check_eq($sformatf("rdata of address %0d", addr), rdata, expv);
	endtask

	task automatic stream_byte(input logic [7:0] b, input logic with_drop);
		int waited;
		int gap;
		model_byte(b);
		ts_valid = 1'b1;
		ts_data = b;
		@(posedge clk);
		#10;
		if (with_drop) begin
			ts_data = ~b;  // mapper busy, byte gets dropped
			@(posedge clk);
			#10;
		end
		ts_valid = 1'b0;
		waited = 0;
		while (obs_re.size() < exp_re.size()) begin
			if (waited == 64) begin
				report_timeout("output samples");
			end
			@(posedge clk);
			#10;
			waited++;
		end
		gap = 16 + int'($urandom % 16);
		repeat (gap) @(posedge clk);
		#10;
		check_eq("number of samples", 32'(obs_re.size()), 32'(exp_re.size()));
		while (checked < exp_re.size()) begin
			check_eq($sformatf("sample_re %0d", checked), obs_re[checked], exp_re[checked]);
			check_eq($sformatf("sample_im %0d", checked), obs_im[checked], exp_im[checked]);
			checked++;
		end
	endtask

	initial begin
		logic [7:0] b;
		logic [31:0] expv;
		rst_n = 1'b0;
		wen = 1'b0;
		wstrb = '0;
		waddr = '0;
		wdata = '0;
		ren = 1'b0;
		raddr = '0;
		ts_valid = 1'b0;
		ts_data = '0;
		void'($urandom(32'hfae441af));
		repeat (2) @(posedge clk);
		#10;
		rst_n = 1'b1;
		check_eq("rdata after reset", rdata, 32'h0);
		for (int i = 0; i < N_ENTRIES; i++) begin
			case (STIM[i].kind)
				K_WR: write_reg(STIM[i].strb, STIM[i].addr, STIM[i].data);
				K_RD: begin
					expv = (STIM[i].addr == ADDR_SAMPLE_CNT) ? 32'(exp_re.size()) : STIM[i].data;
					read_reg(STIM[i].addr, expv);
				end
				default: begin
					b = STIM[i].rnd ? 8'($urandom) : STIM[i].data[7:0];
					stream_byte(b, STIM[i].kind == K_BUSY);
				end
			endcase
		end
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: files.f
dvbs2_pkg.sv
dvbs2_cfg_regs.sv
symbol_mapper.sv
srrc_tap.sv
srrc_output_stage.sv
dvbs2_mod_top.sv
tb_dvbs2_mod.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DVB-S2 modulator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f files.f --top-module tb_dvbs2_mod -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'All tests passed!'; then
	exit 0
fi
exit 1
